/* Bender.yml */
package:
  name: ti_adc

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/adc_pkg.sv
      - hdl/adc_cfg_regs.sv
      - hdl/adc_slice.sv
      - hdl/slice_merger.sv
      - hdl/ti_adc_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - verif/ti_adc_properties.sv
      - verif/ti_adc_tb.sv

/* filelist.f */
+incdir+hdl
hdl/adc_pkg.sv
hdl/adc_cfg_regs.sv
hdl/adc_slice.sv
hdl/slice_merger.sv
hdl/ti_adc_top.sv
verif/ti_adc_properties.sv
verif/ti_adc_tb.sv

/* hdl/adc_cfg_regs.sv */
// APB slave with pready tied high; offsets read back sign extended, unmapped reads return 0
`timescale 1ns/1ns
`default_nettype none

`include "adc_macros.svh"

module adc_cfg_regs import adc_pkg::*; (
    input  wire logic      clk_adder,
    input  wire logic      rstb,
    input  wire apb_addr_t paddr,
    input  wire logic      psel,
    input  wire logic      penable,
    input  wire logic      pwrite,
    input  wire apb_data_t pwdata,
    output apb_data_t      prdata,
    output logic           pready,
    output logic           pslverr,
    input  wire logic      overrun,
    output logic [1:0]     en_slice,
    output logic [1:0]     alws_on,
    output phase_t         init0,
    output phase_t         init1,
    output code_t          offset0,
    output code_t          offset1,
    output gain_t          gain0,
    output gain_t          gain1
);

    localparam gain_t  GAIN_ONE  = gain_t'(1 << `ADC_GAIN_FRAC);
    localparam phase_t INIT1_RST = phase_t'(2);

    logic access;
    logic wr_en;
    logic addr_hit;
    logic stat_overrun;

    assign access  = psel & penable;
    assign wr_en   = access & pwrite;
    assign pready  = 1'b1;
    assign pslverr = access & ~addr_hit;

    // read mux, valid through the access cycle
    always_comb begin
        addr_hit = 1'b1;
        prdata   = '0;
        case (paddr)
            `ADC_ADDR_CTRL:  prdata = apb_data_t'({alws_on, en_slice});
            `ADC_ADDR_INIT:  prdata = apb_data_t'({init1, 6'b0, init0});
            `ADC_ADDR_OFS0:  prdata = apb_data_t'(offset0);
            `ADC_ADDR_OFS1:  prdata = apb_data_t'(offset1);
            `ADC_ADDR_GAIN0: prdata = apb_data_t'(gain0);
            `ADC_ADDR_GAIN1: prdata = apb_data_t'(gain1);
            `ADC_ADDR_STAT:  prdata = apb_data_t'(stat_overrun);
            default:         addr_hit = 1'b0;
        endcase
    end

    ////////////////////
    // slice settings
    ////////////////////

    always_ff @(posedge clk_adder or negedge rstb) begin
        if (!rstb) begin
            en_slice <= '0;
            alws_on  <= '0;
            init0    <= '0;
            init1    <= INIT1_RST;
            offset0  <= '0;
            offset1  <= '0;
            gain0    <= GAIN_ONE;
            gain1    <= GAIN_ONE;
        end else if (wr_en) begin
            case (paddr)
                `ADC_ADDR_CTRL: begin
                    en_slice <= pwdata[1:0];
                    alws_on  <= pwdata[3:2];
                end
                `ADC_ADDR_INIT: begin
                    init0 <= pwdata[`ADC_NDIV-1:0];
                    init1 <= pwdata[8 +: `ADC_NDIV];
                end
                `ADC_ADDR_OFS0:  offset0 <= pwdata[`ADC_CODE_W-1:0];
                `ADC_ADDR_OFS1:  offset1 <= pwdata[`ADC_CODE_W-1:0];
                `ADC_ADDR_GAIN0: gain0 <= pwdata[`ADC_GAIN_W-1:0];
                `ADC_ADDR_GAIN1: gain1 <= pwdata[`ADC_GAIN_W-1:0];
                default: ;
            endcase
        end
    end

    // sticky overrun, a new pulse wins over a clear in the same cycle
    always_ff @(posedge clk_adder or negedge rstb) begin
        if (!rstb) begin
            stat_overrun <= 1'b0;
        end else if (overrun) begin
            stat_overrun <= 1'b1;
        end else if (wr_en && (paddr == `ADC_ADDR_STAT) && pwdata[0]) begin
            stat_overrun <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* hdl/adc_macros.svh */
// all sizes are compile time only; ADC_DIFF_W must hold code difference plus offset without wrap
`ifndef ADC_MACROS_SVH
`define ADC_MACROS_SVH

////////////////////
// data widths
////////////////////

`define ADC_CODE_W      12
`define ADC_DIFF_W      14
`define ADC_MAG_W       7
`define ADC_GAIN_W      8

// gain is fixed point, 1 << ADC_GAIN_FRAC is unity
`define ADC_GAIN_FRAC   6
// right shift from corrected difference to output lsb
`define ADC_QSHIFT      4

// divider counter width, one sample every 2**ADC_NDIV cycles
`define ADC_NDIV        2

`define ADC_APB_ADDR_W  8
`define ADC_APB_DATA_W  32

////////////////////
// register map
////////////////////

`define ADC_ADDR_CTRL   8'h00
`define ADC_ADDR_INIT   8'h04
`define ADC_ADDR_OFS0   8'h08
`define ADC_ADDR_OFS1   8'h0C
`define ADC_ADDR_GAIN0  8'h10
`define ADC_ADDR_GAIN1  8'h14
`define ADC_ADDR_STAT   8'h18

`endif

/* hdl/adc_pkg.sv */
// vector types only, every width comes from adc_macros.svh and codes are two's complement
`default_nettype none

`include "adc_macros.svh"

package adc_pkg;

    ////////////////////
    // sample path
    ////////////////////

    // signed input code as delivered on vin_p / vin_n
    typedef logic signed [`ADC_CODE_W-1:0] code_t;

    // difference after offset correction, full width
    typedef logic signed [`ADC_DIFF_W-1:0] diff_t;

    // unsigned fixed point gain
    typedef logic [`ADC_GAIN_W-1:0] gain_t;

    // output magnitude, sign travels separately
    typedef logic [`ADC_MAG_W-1:0] mag_t;

    // divider init and counter value
    typedef logic [`ADC_NDIV-1:0] phase_t;

    ////////////////////
    // register port
    ////////////////////

    typedef logic [`ADC_APB_ADDR_W-1:0] apb_addr_t;
    typedef logic [`ADC_APB_DATA_W-1:0] apb_data_t;

endpackage

`default_nettype wire

/* hdl/adc_slice.sv */
// enable slices only after en_sync has settled so init alone sets the phase; latency 3 edges
`timescale 1ns/1ns
`default_nettype none

`include "adc_macros.svh"

module adc_slice import adc_pkg::*; (
    input  wire logic   clk_adder,
    input  wire logic   rstb,
    input  wire logic   en_slice,
    input  wire logic   alws_on,
    input  wire phase_t init,
    input  wire logic   en_sync_in,
    output logic        en_sync_out,
    input  wire code_t  vin_p,
    input  wire code_t  vin_n,
    input  wire code_t  offset,
    input  wire gain_t  gain,
    output logic        res_valid,
    output logic        res_sign,
    output mag_t        res_mag
);

    localparam int PROD_W   = `ADC_DIFF_W + `ADC_GAIN_W;
    localparam int SHIFT    = `ADC_GAIN_FRAC + `ADC_QSHIFT;
    localparam int SCALED_W = PROD_W - SHIFT;
    localparam mag_t MAG_MAX = '1;

    logic   en_sync_sampled;
    logic   en_sync;
    phase_t count;
    logic   samp_strobe;

    diff_t                  d_next;
    diff_t                  s1_diff;
    logic                   s1_valid;
    logic [`ADC_DIFF_W-1:0] s1_abs;
    logic [PROD_W-1:0]      s2_prod;
    logic                   s2_sign;
    logic                   s2_valid;
    logic [SCALED_W-1:0]    s2_scaled;
    logic                   s2_over;

    ////////////////////
    // enable sync
    ////////////////////

    always_ff @(posedge clk_adder or negedge rstb) begin
        if (!rstb) begin
            en_sync_sampled <= 1'b0;
            en_sync_out     <= 1'b0;
        end else begin
            en_sync_sampled <= en_sync_in;
            en_sync_out     <= en_sync_sampled;
        end
    end

    assign en_sync = en_sync_sampled & en_slice;

    // phase divider, all ones is the sample point
    always_ff @(posedge clk_adder or negedge rstb) begin
        if (!rstb) begin
            count <= init;
        end else if (!en_sync) begin
            count <= init;
        end else if (alws_on) begin
            count <= '1;
        end else begin
            count <= count + 1'b1;
        end
    end

    assign samp_strobe = en_sync & (count == '1);

    ////////////////////
    // sample pipeline
    ////////////////////

    // full width so offset cannot wrap
    assign d_next = diff_t'(vin_p) - diff_t'(vin_n) + diff_t'(offset);

    assign s1_abs    = s1_diff[`ADC_DIFF_W-1] ? -s1_diff : s1_diff;
    assign s2_scaled = s2_prod[PROD_W-1:SHIFT];
    assign s2_over   = |s2_scaled[SCALED_W-1:`ADC_MAG_W];

    always_ff @(posedge clk_adder or negedge rstb) begin
        if (!rstb) begin
            s1_valid  <= 1'b0;
            s2_valid  <= 1'b0;
            res_valid <= 1'b0;
        end else begin
            s1_valid  <= samp_strobe;
            s2_valid  <= s1_valid;
            res_valid <= s2_valid;
        end
    end

    always_ff @(posedge clk_adder) begin
        if (samp_strobe) begin
            s1_diff <= d_next;
        end
        // zero counts as positive
        s2_sign  <= ~s1_diff[`ADC_DIFF_W-1];
        s2_prod  <= s1_abs * gain;
        res_sign <= s2_sign;
        res_mag  <= s2_over ? MAG_MAX : s2_scaled[`ADC_MAG_W-1:0];
    end

endmodule

`default_nettype wire

/* hdl/slice_merger.sv */
// no back-pressure; slice 0 always wins and slice 1 results beyond one held entry are lost
`timescale 1ns/1ns
`default_nettype none

module slice_merger import adc_pkg::*; (
    input  wire logic clk_adder,
    input  wire logic rstb,
    input  wire logic res0_valid,
    input  wire logic res0_sign,
    input  wire mag_t res0_mag,
    input  wire logic res1_valid,
    input  wire logic res1_sign,
    input  wire mag_t res1_mag,
    output logic      out_valid,
    output logic      out_sign,
    output mag_t      out_mag,
    output logic      out_slice,
    output logic      overrun
);

    logic sel_valid;
    logic sel_sign;
    mag_t sel_mag;
    logic sel_slice;
    logic hold_valid;
    logic hold_valid_next;
    logic hold_sign;
    mag_t hold_mag;
    logic hold_load;
    logic drop;

    always_comb begin
        sel_valid       = 1'b1;
        sel_sign        = res0_sign;
        sel_mag         = res0_mag;
        sel_slice       = 1'b0;
        hold_load       = 1'b0;
        hold_valid_next = 1'b0;
        if (res0_valid) begin
            // slice 1 parks in the hold entry if it is free
            hold_load       = res1_valid & ~hold_valid;
            hold_valid_next = hold_valid | res1_valid;
        end else if (hold_valid) begin
            sel_sign        = hold_sign;
            sel_mag         = hold_mag;
            sel_slice       = 1'b1;
            hold_load       = res1_valid;
            hold_valid_next = res1_valid;
        end else begin
            sel_valid = res1_valid;
            sel_sign  = res1_sign;
            sel_mag   = res1_mag;
            sel_slice = 1'b1;
        end
    end

    assign drop = res0_valid & res1_valid & hold_valid;

    always_ff @(posedge clk_adder or negedge rstb) begin
        if (!rstb) begin
            out_valid  <= 1'b0;
            hold_valid <= 1'b0;
            overrun    <= 1'b0;
        end else begin
            out_valid  <= sel_valid;
            hold_valid <= hold_valid_next;
            overrun    <= drop;
        end
    end

    always_ff @(posedge clk_adder) begin
        out_sign  <= sel_sign;
        out_mag   <= sel_mag;
        out_slice <= sel_slice;
        if (hold_load) begin
            hold_sign <= res1_sign;
            hold_mag  <= res1_mag;
        end
    end

endmodule

`default_nettype wire

/* hdl/ti_adc_top.sv */
// two slices share vin_p/vin_n; output stream cannot stall, overflow only shows in STAT
`timescale 1ns/1ns
`default_nettype none

module ti_adc_top import adc_pkg::*; (
    input  wire logic      clk_adder,
    input  wire logic      rstb,
    input  wire apb_addr_t paddr,
    input  wire logic      psel,
    input  wire logic      penable,
    input  wire logic      pwrite,
    input  wire apb_data_t pwdata,
    output apb_data_t      prdata,
    output logic           pready,
    output logic           pslverr,
    input  wire code_t     vin_p,
    input  wire code_t     vin_n,
    input  wire logic      en_sync_in,
    output logic           en_sync_out,
    output logic           out_valid,
    output logic           out_sign,
    output mag_t           out_mag,
    output logic           out_slice
);

    logic [1:0] en_slice;
    logic [1:0] alws_on;
    phase_t     init0;
    phase_t     init1;
    code_t      offset0;
    code_t      offset1;
    gain_t      gain0;
    gain_t      gain1;
    logic       overrun;
    logic       en_sync_mid;
    logic       res0_valid;
    logic       res0_sign;
    mag_t       res0_mag;
    logic       res1_valid;
    logic       res1_sign;
    mag_t       res1_mag;

    adc_cfg_regs u_regs (
        .clk_adder (clk_adder),
        .rstb      (rstb),
        .paddr     (paddr),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .overrun   (overrun),
        .en_slice  (en_slice),
        .alws_on   (alws_on),
        .init0     (init0),
        .init1     (init1),
        .offset0   (offset0),
        .offset1   (offset1),
        .gain0     (gain0),
        .gain1     (gain1)
    );

    ////////////////////
    // slices
    ////////////////////

    adc_slice u_slice0 (
        .clk_adder   (clk_adder),
        .rstb        (rstb),
        .en_slice    (en_slice[0]),
        .alws_on     (alws_on[0]),
        .init        (init0),
        .en_sync_in  (en_sync_in),
        .en_sync_out (en_sync_mid),
        .vin_p       (vin_p),
        .vin_n       (vin_n),
        .offset      (offset0),
        .gain        (gain0),
        .res_valid   (res0_valid),
        .res_sign    (res0_sign),
        .res_mag     (res0_mag)
    );

    // enable chain continues through slice 1
    adc_slice u_slice1 (
        .clk_adder   (clk_adder),
        .rstb        (rstb),
        .en_slice    (en_slice[1]),
        .alws_on     (alws_on[1]),
        .init        (init1),
        .en_sync_in  (en_sync_mid),
        .en_sync_out (en_sync_out),
        .vin_p       (vin_p),
        .vin_n       (vin_n),
        .offset      (offset1),
        .gain        (gain1),
        .res_valid   (res1_valid),
        .res_sign    (res1_sign),
        .res_mag     (res1_mag)
    );

    slice_merger u_merger (
        .clk_adder  (clk_adder),
        .rstb       (rstb),
        .res0_valid (res0_valid),
        .res0_sign  (res0_sign),
        .res0_mag   (res0_mag),
        .res1_valid (res1_valid),
        .res1_sign  (res1_sign),
        .res1_mag   (res1_mag),
        .out_valid  (out_valid),
        .out_sign   (out_sign),
        .out_mag    (out_mag),
        .out_slice  (out_slice),
        .overrun    (overrun)
    );

endmodule

`default_nettype wire

/* verif/ti_adc_properties.sv */
// bound twice; where the host scope has no APB or phase settings those inputs are tied off
`timescale 1ns/1ns
`default_nettype none

module ti_adc_properties (
    input wire logic clk_adder,
    input wire logic rstb,
    input wire logic out_valid,
    input wire logic out_slice,
    input wire logic overrun,
    input wire logic phase_differ,
    input wire logic apb_access,
    input wire logic pready
);

    int fail_cnt = 0;

    // nothing leaves the block while reset is held
    reset_quiet: assert property (@(posedge clk_adder) !rstb |-> (!out_valid && !overrun))
        else begin
            $error("output or overrun active during reset");
            fail_cnt = fail_cnt + 1;
        end

    // distinct phases never give back to back outputs of one slice
    slice_alternates: assert property (@(posedge clk_adder) disable iff (!rstb)
        (out_valid && $past(out_valid) && $past(phase_differ))
            |-> (out_slice != $past(out_slice)))
        else begin
            $error("same slice on two consecutive outputs");
            fail_cnt = fail_cnt + 1;
        end

    apb_ready: assert property (@(posedge clk_adder) disable iff (!rstb)
        apb_access |-> pready)
        else begin
            $error("pready low during an APB access");
            fail_cnt = fail_cnt + 1;
        end

endmodule

////////////////////
// binds
////////////////////

bind slice_merger ti_adc_properties u_props (
    .clk_adder    (clk_adder),
    .rstb         (rstb),
    .out_valid    (out_valid),
    .out_slice    (out_slice),
    .overrun      (overrun),
    .phase_differ (1'b0),
    .apb_access   (1'b0),
    .pready       (1'b1)
);

bind ti_adc_top ti_adc_properties u_props (
    .clk_adder    (clk_adder),
    .rstb         (rstb),
    .out_valid    (out_valid),
    .out_slice    (out_slice),
    .overrun      (overrun),
    .phase_differ ((init0 != init1) && (alws_on == 2'b00) && (en_slice == 2'b11)),
    .apb_access   (psel && penable),
    .pready       (pready)
);

`default_nettype wire

/* verif/ti_adc_tb.sv */
// outputs sampled on the falling edge; assumes no other APB master and equal settings per slice
`timescale 1ns/1ns
`default_nettype none

`include "adc_macros.svh"

module ti_adc_tb import adc_pkg::*; ();

    localparam int NUM_ENTRIES = 14;
    localparam int NUM_FIXED   = 9;
    localparam int TIMEOUT     = 32;

    logic      clk_adder;
    logic      rstb;
    apb_addr_t paddr;
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_data_t pwdata;
    apb_data_t prdata;
    logic      pready;
    logic      pslverr;
    code_t     vin_p;
    code_t     vin_n;
    logic      en_sync_in;
    logic      en_sync_out;
    logic      out_valid;
    logic      out_sign;
    mag_t      out_mag;
    logic      out_slice;

    // stimulus table, one row per input setting
    int tbl_p    [NUM_ENTRIES];
    int tbl_n    [NUM_ENTRIES];
    int tbl_ofs  [NUM_ENTRIES];
    int tbl_gain [NUM_ENTRIES];
    int tbl_hold [NUM_ENTRIES];

    int seed;
    int cycle_cnt = 0;
    int exp_sign;
    int exp_mag;

    ti_adc_top u_dut (
        .clk_adder   (clk_adder),
        .rstb        (rstb),
        .paddr       (paddr),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .vin_p       (vin_p),
        .vin_n       (vin_n),
        .en_sync_in  (en_sync_in),
        .en_sync_out (en_sync_out),
        .out_valid   (out_valid),
        .out_sign    (out_sign),
        .out_mag     (out_mag),
        .out_slice   (out_slice)
    );

    initial begin
        clk_adder = 1'b0;
        forever #2 clk_adder = ~clk_adder;
    end

    always @(posedge clk_adder) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    always @(negedge clk_adder) begin
        if (u_dut.u_props.fail_cnt != 0 || u_dut.u_merger.u_props.fail_cnt != 0) begin
            $display("A bound assertion failed");
            $display("** FAIL **");
            $fatal(1, "assertion failure");
        end
    end

    ////////////////////
    // checking helpers
    ////////////////////

    task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
                            input string msg);
        if (actual !== expected) begin
            $display("Mismatch at %0t ns: %s, got 0x%0h, expected 0x%0h",
                     $time, msg, actual, expected);
            $display("** FAIL **");
            $fatal(1, "stopped at first error");
        end
    endtask

    // on_sync selects en_sync_out, otherwise out_valid
    task automatic wait_signal(input logic on_sync, input string what);
        int waited;
        waited = 0;
        while ((on_sync ? en_sync_out : out_valid) !== 1'b1) begin
            if (waited >= TIMEOUT) begin
                $display("Timed out after %0d cycles waiting for %s", TIMEOUT, what);
                $display("** FAIL **");
                $fatal(1, "timeout");
            end else begin
                @(negedge clk_adder);
                waited++;
            end
        end
    endtask

    // setup then access cycle, response checked just after the falling edge
    task automatic apb_transfer(input apb_addr_t addr, input logic write, input apb_data_t data,
                                input apb_data_t exp_data, input logic exp_err);
        paddr   = addr;
        pwrite  = write;
        pwdata  = data;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge clk_adder);
        penable = 1'b1;
        #1;
        check_eq(pready, 1'b1, "pready in access cycle");
        check_eq(pslverr, exp_err, $sformatf("pslverr at address 0x%02h", addr));
        if (!write) begin
            check_eq(prdata, exp_data, $sformatf("read data at address 0x%02h", addr));
        end
        @(negedge clk_adder);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_write(input apb_addr_t addr, input apb_data_t data,
                             input logic exp_err = 1'b0);
        apb_transfer(addr, 1'b1, data, '0, exp_err);
    endtask

    task automatic apb_read(input apb_addr_t addr, input apb_data_t exp_data,
                            input logic exp_err = 1'b0);
        apb_transfer(addr, 1'b0, '0, exp_data, exp_err);
    endtask

    ////////////////////
    // reference model
    ////////////////////

    function automatic int scaled_mag(input int d, input int gain);
        int mag;
        mag = ((d < 0) ? -d : d) * gain / (1 << (`ADC_GAIN_FRAC + `ADC_QSHIFT));
        return (mag > (1 << `ADC_MAG_W) - 1) ? (1 << `ADC_MAG_W) - 1 : mag;
    endfunction

    task automatic load_expected(input int idx);
        int d;
        d = tbl_p[idx] - tbl_n[idx] + tbl_ofs[idx];
        exp_sign = (d >= 0) ? 1 : 0;
        exp_mag  = scaled_mag(d, tbl_gain[idx]);
    endtask

    task automatic check_sample(input string what);
        check_eq(out_sign, exp_sign, {what, " sign"});
        check_eq(out_mag, exp_mag, {what, " magnitude"});
    endtask

    task automatic set_entry(input int idx, input int p, input int n, input int ofs,
                             input int gain, input int hold);
        tbl_p[idx]    = p;
        tbl_n[idx]    = n;
        tbl_ofs[idx]  = ofs;
        tbl_gain[idx] = gain;
        tbl_hold[idx] = hold;
    endtask

    task automatic fill_table();
        set_entry(0, 100, 20, 0, 64, 4);
        set_entry(1, -300, 200, 0, 64, 4);
        set_entry(2, 50, 50, 0, 64, 4);
        set_entry(3, 400, 100, -44, 64, 4);
        set_entry(4, 100, 300, 150, 128, 4);
        set_entry(5, 1000, -200, 0, 96, 4);
        // clamp cases
        set_entry(6, 2047, -2048, 0, 64, 4);
        set_entry(7, -2048, 2047, -2048, 255, 4);
        set_entry(8, 1500, 0, 600, 200, 4);
        for (int i = NUM_FIXED; i < NUM_ENTRIES; i++) begin
            set_entry(i, int'(code_t'($random(seed))), int'(code_t'($random(seed))),
                      int'(code_t'($random(seed))), int'(gain_t'($random(seed))), 5);
        end
    endtask

    initial begin
        logic last_slice;
        int   last_cycle;
        int   start_cycle;

        rstb       = 1'b1;
        paddr      = '0;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        pwdata     = '0;
        vin_p      = '0;
        vin_n      = '0;
        en_sync_in = 1'b0;
        seed       = 32'h0cc0_cf0e;
        fill_table();
        @(negedge clk_adder);
        rstb = 1'b0;
        repeat (4) @(negedge clk_adder);
        rstb = 1'b1;
        check_eq(out_valid, 1'b0, "out_valid after reset");
        check_eq(en_sync_out, 1'b0, "en_sync_out after reset");

        ////////////////////
        // register access
        ////////////////////

        apb_read(`ADC_ADDR_CTRL, 32'h0);
        apb_read(`ADC_ADDR_INIT, 32'h200);
        apb_read(`ADC_ADDR_OFS0, 32'h0);
        apb_read(`ADC_ADDR_OFS1, 32'h0);
        apb_read(`ADC_ADDR_GAIN0, 32'h40);
        apb_read(`ADC_ADDR_GAIN1, 32'h40);
        apb_read(`ADC_ADDR_STAT, 32'h0);
        apb_write(`ADC_ADDR_CTRL, 32'hA);
        apb_read(`ADC_ADDR_CTRL, 32'hA);
        apb_write(`ADC_ADDR_INIT, 32'h301);
        apb_read(`ADC_ADDR_INIT, 32'h301);
        apb_write(`ADC_ADDR_OFS0, 32'h123);
        apb_read(`ADC_ADDR_OFS0, 32'h123);
        apb_write(`ADC_ADDR_OFS1, 32'hFF0);
        apb_read(`ADC_ADDR_OFS1, 32'hFFFF_FFF0);
        apb_write(`ADC_ADDR_GAIN0, 32'h55);
        apb_read(`ADC_ADDR_GAIN0, 32'h55);
        apb_write(`ADC_ADDR_GAIN1, 32'hAA);
        apb_read(`ADC_ADDR_GAIN1, 32'hAA);
        // unmapped address
        apb_write(8'h1C, 32'hFFFF, 1'b1);
        apb_read(8'h1C, 32'h0, 1'b1);
        apb_write(`ADC_ADDR_CTRL, 32'h0);
        apb_write(`ADC_ADDR_INIT, 32'h200);

        // enable chain, two stages per slice
        en_sync_in  = 1'b1;
        start_cycle = cycle_cnt;
        wait_signal(1'b1, "en_sync_out to follow en_sync_in");
        check_eq(cycle_cnt - start_cycle, 4, "en_sync chain latency");

        ////////////////////
        // interleaved table
        ////////////////////

        apb_write(`ADC_ADDR_CTRL, 32'h3);
        for (int e = 0; e < NUM_ENTRIES; e++) begin
            vin_p = code_t'(tbl_p[e]);
            vin_n = code_t'(tbl_n[e]);
            apb_write(`ADC_ADDR_OFS0, apb_data_t'(tbl_ofs[e]));
            apb_write(`ADC_ADDR_OFS1, apb_data_t'(tbl_ofs[e]));
            apb_write(`ADC_ADDR_GAIN0, apb_data_t'(tbl_gain[e]));
            apb_write(`ADC_ADDR_GAIN1, apb_data_t'(tbl_gain[e]));
            load_expected(e);
            // let samples taken before the change leave the pipeline
            repeat (4) @(negedge clk_adder);
            for (int s = 0; s < tbl_hold[e]; s++) begin
                wait_signal(1'b0, "an interleaved sample");
                check_sample($sformatf("entry %0d sample %0d", e, s));
                if (s > 0) begin
                    check_eq(out_slice, !last_slice, "out_slice alternation");
                    check_eq(cycle_cnt - last_cycle, 2, "interleaved output spacing");
                end
                last_slice = out_slice;
                last_cycle = cycle_cnt;
                @(negedge clk_adder);
            end
        end

        // slice 0 alone, firing every cycle
        apb_write(`ADC_ADDR_CTRL, 32'h5);
        repeat (8) @(negedge clk_adder);
        wait_signal(1'b0, "always-on output");
        for (int s = 0; s < 12; s++) begin
            check_eq(out_valid, 1'b1, "out_valid on every cycle in always-on");
            check_eq(out_slice, 1'b0, "out_slice in always-on");
            check_sample("always-on sample");
            @(negedge clk_adder);
        end

        ////////////////////
        // collisions
        ////////////////////

        apb_write(`ADC_ADDR_CTRL, 32'h0);
        repeat (8) @(negedge clk_adder);
        apb_write(`ADC_ADDR_INIT, 32'h000);
        apb_write(`ADC_ADDR_CTRL, 32'h3);
        for (int s = 0; s < 4; s++) begin
            wait_signal(1'b0, "first result of a collision pair");
            check_eq(out_slice, 1'b0, "collision pair, slice 0 first");
            check_sample("collision slice 0");
            @(negedge clk_adder);
            check_eq(out_valid, 1'b1, "held slice 1 result follows");
            check_eq(out_slice, 1'b1, "collision pair, slice 1 second");
            check_sample("collision slice 1");
            @(negedge clk_adder);
        end

        // slice 1 always-on overflows the hold entry
        apb_write(`ADC_ADDR_CTRL, 32'hB);
        repeat (16) @(negedge clk_adder);
        apb_read(`ADC_ADDR_STAT, 32'h1);
        apb_write(`ADC_ADDR_CTRL, 32'h0);
        repeat (8) @(negedge clk_adder);
        apb_write(`ADC_ADDR_STAT, 32'h1);
        apb_read(`ADC_ADDR_STAT, 32'h0);

        if (u_dut.u_props.fail_cnt == 0 && u_dut.u_merger.u_props.fail_cnt == 0) begin
            $display("** PASS **");
            $finish;
        end else begin
            $display("Bound assertions failed during the run");
            $display("** FAIL **");
            $fatal(1, "assertion failure");
        end
    end

endmodule

`default_nettype wire
